// File: Bender.yml
package:
  name: icache

sources:
  - common/icache_pkg.sv
  - icache/icache_tagv.sv
  - icache/icache_data.sv
  - icache/icache_lru.sv
  - icache/icache_ctrl.sv
  - icache/icache_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_mem_model.sv
      - tests/icache_tb.sv

// File: common/icache_pkg.sv
package icache_pkg;

    ////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////

    localparam int index_width  = 4;
    localparam int offset_width = 2;
    localparam int sets         = 1 << index_width;
    localparam int line_width   = 32 * (1 << offset_width);
    // what is left after index, word offset and byte bits
    localparam int tag_width    = 32 - index_width - offset_width - 2;

    ////////////////////////////////////////////////////////////
    // fetch address, raw word or split fields
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [tag_width-1:0]    tag;
        logic [index_width-1:0]  index;
        logic [offset_width-1:0] word;
        logic [1:0]              byte_sel;
    } fetch_fields_s;

    typedef union packed {
        logic [31:0]   raw;
        fetch_fields_s f;
    } fetch_addr_u;

    // maintenance ops
    typedef enum logic [1:0] {
        op_index_inv = 2'b01,
        op_inv_all   = 2'b10
    } icache_op_e;

    // contents of the request buffer
    typedef struct packed {
        fetch_addr_u addr;
        logic        uncached;
        logic        op;
        icache_op_e  op_kind;
    } fetch_req_s;

    // inst0 is the word at pc, inst1 only meaningful with second_valid
    typedef struct packed {
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic        second_valid;
        logic [31:0] pc;
    } fetch_rsp_s;

endpackage

// File: icache/icache_ctrl.sv
`timescale 1ns/10ps

module icache_ctrl import icache_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        fetch_valid,
    input  fetch_req_s  fetch_req,
    input  logic        hold,
    output logic        busy,
    output logic        op_ack,
    output fetch_req_s  rbuf,
    input  logic [1:0]  hit,
    input  logic        victim,
    output logic        mem_req,
    output logic [31:0] mem_addr,
    output logic        mem_uncached,
    input  logic        mem_data_ok,
    output logic        fill_en,
    output logic        fill_way,
    output logic        lru_touch,
    output logic        lru_way,
    output logic        inv_index_en,
    output logic        inv_all_en,
    output logic        result_en,
    output logic        from_mem,
    output logic        sel_way
);

    typedef enum logic [1:0] {
        s_idle,
        s_refill,
        s_uncached,
        s_return
    } state_e;

    state_e state;
    state_e state_next;
    logic   pend;
    logic   accept;
    logic   lookup;
    logic   lk_hit;
    logic   lk_miss;
    logic   waiting;

    ////////////////////////////////////////////////////////////
    // request buffer
    ////////////////////////////////////////////////////////////

    assign accept = fetch_valid && !busy && !hold;

    // pend marks a buffered request whose lookup is this cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            rbuf <= '0;
            pend <= 1'b0;
        end else begin
            pend <= accept;
            if (accept) begin
                rbuf <= fetch_req;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // lookup decode
    ////////////////////////////////////////////////////////////

    assign lookup  = (state == s_idle) && pend;
    assign lk_hit  = lookup && !rbuf.op && !rbuf.uncached && (|hit);
    // uncached always goes to memory whatever the tags say
    assign lk_miss = lookup && !rbuf.op && (rbuf.uncached || !(|hit));
    assign waiting = (state == s_refill) || (state == s_uncached);

    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                if (lk_miss) begin
                    state_next = rbuf.uncached ? s_uncached : s_refill;
                end
            end
            s_refill, s_uncached: begin
                if (mem_data_ok) begin
                    state_next = s_return;
                end
            end
            default: state_next = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////

    // busy and mem_req rise together in the lookup cycle of a miss
    assign busy         = lk_miss || waiting;
    assign mem_req      = lk_miss || waiting;
    assign mem_uncached = rbuf.uncached;
    assign mem_addr     = rbuf.uncached ? rbuf.addr.raw
                        : {rbuf.addr.raw[31:offset_width+2], {(offset_width+2){1'b0}}};

    assign op_ack       = lookup && rbuf.op;
    assign inv_index_en = op_ack && (rbuf.op_kind == op_index_inv);
    assign inv_all_en   = op_ack && (rbuf.op_kind == op_inv_all);

    // refill lands in the victim way in the return cycle
    assign from_mem  = (state == s_return);
    assign fill_en   = from_mem && !rbuf.uncached;
    assign fill_way  = victim;
    assign result_en = lk_hit || from_mem;
    assign sel_way   = hit[1];

    assign lru_touch = lk_hit || fill_en;
    assign lru_way   = from_mem ? victim : hit[1];

    a_mem_addr_stable: assert property (
        @(posedge clk) disable iff (reset)
        mem_req && !mem_data_ok |=> mem_req && $stable(mem_addr)
    ) else $error("icache_ctrl: mem_addr moved during request, mem_addr=%h", mem_addr);

    // a buffered request always finds the FSM idle for its lookup
    a_no_accept_busy: assert property (
        @(posedge clk) disable iff (reset) pend |-> state == s_idle
    ) else $error("icache_ctrl: request accepted while busy, state=%h", state);

endmodule

// File: icache/icache_data.sv
`timescale 1ns/10ps

module icache_data import icache_pkg::*; (
    input  logic                   clk,
    input  logic [index_width-1:0] rd_index,
    output logic [line_width-1:0]  rd_line0,
    output logic [line_width-1:0]  rd_line1,
    input  logic                   wr_en,
    input  logic                   wr_way,
    input  logic [index_width-1:0] wr_index,
    input  logic [line_width-1:0]  wr_line
);

    logic [line_width-1:0]  lines [2][sets];
    logic [index_width-1:0] rd_index_q;

    // whole line written at once on refill
    always_ff @(posedge clk) begin
        rd_index_q <= rd_index;
        if (wr_en) begin
            lines[wr_way][wr_index] <= wr_line;
        end
    end

    // registered read, both ways out for the selector
    assign rd_line0 = lines[0][rd_index_q];
    assign rd_line1 = lines[1][rd_index_q];

endmodule

// File: icache/icache_lru.sv
`timescale 1ns/10ps

module icache_lru import icache_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [index_width-1:0] index,
    input  logic                   touch,
    input  logic                   touch_way,
    output logic                   victim
);

    // way used last, per set
    logic [sets-1:0] last_used;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_used <= '0;
        end else if (touch) begin
            last_used[index] <= touch_way;
        end
    end

    // with two ways the victim is simply the other one
    assign victim = ~last_used[index];

endmodule

// File: icache/icache_tagv.sv
`timescale 1ns/10ps

module icache_tagv import icache_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [index_width-1:0] rd_index,
    input  logic [tag_width-1:0]   cmp_tag,
    output logic [1:0]             hit,
    input  logic                   wr_en,
    input  logic                   wr_way,
    input  logic [index_width-1:0] wr_index,
    input  logic [tag_width-1:0]   wr_tag,
    input  logic                   inv_index_en,
    input  logic                   inv_all_en,
    input  logic [index_width-1:0] inv_index
);

    logic [tag_width-1:0]   tags [2][sets];
    logic [1:0][sets-1:0]   valid;
    logic [index_width-1:0] rd_index_q;

    // index registered at acceptance, arrays read behind it
    always_ff @(posedge clk) begin
        rd_index_q <= rd_index;
        if (wr_en) begin
            tags[wr_way][wr_index] <= wr_tag;
        end
    end

    // valid bits kept in flops so a full invalidate is one cycle
    always_ff @(posedge clk) begin
        if (reset || inv_all_en) begin
            valid <= '0;
        end else begin
            if (inv_index_en) begin
                valid[0][inv_index] <= 1'b0;
                valid[1][inv_index] <= 1'b0;
            end
            if (wr_en) begin
                valid[wr_way][wr_index] <= 1'b1;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w] = valid[w][rd_index_q] && (tags[w][rd_index_q] == cmp_tag);
        end
    end

    // a line is only ever filled after a miss, so never in both ways
    a_hit_one_way: assert property (
        @(posedge clk) disable iff (reset) !(&hit)
    ) else $error("icache_tagv: tag hit in both ways, hit=%h", hit);

endmodule

// File: icache/icache_top.sv
`timescale 1ns/10ps

module icache_top import icache_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fetch_valid,
    input  fetch_req_s            fetch_req,
    input  logic                  hold,
    output logic                  busy,
    output logic                  op_ack,
    output logic                  rsp_valid,
    output fetch_rsp_s            rsp,
    output logic                  mem_req,
    output logic [31:0]           mem_addr,
    output logic                  mem_uncached,
    input  logic                  mem_data_ok,
    input  logic [line_width-1:0] mem_line
);

    fetch_req_s              rbuf;
    logic                    accept;
    logic [index_width-1:0]  rd_index;
    logic [1:0]              hit;
    logic                    victim;
    logic                    fill_en;
    logic                    fill_way;
    logic                    lru_touch;
    logic                    lru_way;
    logic                    inv_index_en;
    logic                    inv_all_en;
    logic                    result_en;
    logic                    from_mem;
    logic                    sel_way;
    logic [line_width-1:0]   rd_line0;
    logic [line_width-1:0]   rd_line1;
    logic [line_width-1:0]   line_sel;
    logic [offset_width-1:0] word;
    fetch_rsp_s              live_rsp;
    fetch_rsp_s              held_rsp;
    logic                    held_valid;
    logic                    show_held;

    // arrays follow the index the buffer will hold next cycle
    assign accept   = fetch_valid && !busy && !hold;
    assign rd_index = accept ? fetch_req.addr.f.index : rbuf.addr.f.index;

    icache_tagv tagv_i (
        .clk(clk), .reset(reset), .rd_index(rd_index), .cmp_tag(rbuf.addr.f.tag),
        .hit(hit), .wr_en(fill_en), .wr_way(fill_way), .wr_index(rbuf.addr.f.index),
        .wr_tag(rbuf.addr.f.tag), .inv_index_en(inv_index_en), .inv_all_en(inv_all_en),
        .inv_index(rbuf.addr.f.index)
    );

    icache_data data_i (
        .clk(clk), .rd_index(rd_index), .rd_line0(rd_line0), .rd_line1(rd_line1),
        .wr_en(fill_en), .wr_way(fill_way), .wr_index(rbuf.addr.f.index), .wr_line(mem_line)
    );

    icache_lru lru_i (
        .clk(clk), .reset(reset), .index(rbuf.addr.f.index), .touch(lru_touch),
        .touch_way(lru_way), .victim(victim)
    );

    icache_ctrl ctrl_i (
        .clk(clk), .reset(reset), .fetch_valid(fetch_valid), .fetch_req(fetch_req),
        .hold(hold), .busy(busy), .op_ack(op_ack), .rbuf(rbuf), .hit(hit), .victim(victim),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_uncached(mem_uncached),
        .mem_data_ok(mem_data_ok), .fill_en(fill_en), .fill_way(fill_way),
        .lru_touch(lru_touch), .lru_way(lru_way), .inv_index_en(inv_index_en),
        .inv_all_en(inv_all_en), .result_en(result_en), .from_mem(from_mem),
        .sel_way(sel_way)
    );

    ////////////////////////////////////////////////////////////
    // word-pair selector
    ////////////////////////////////////////////////////////////

    // mem_line is still valid in the return cycle, one after mem_data_ok
    assign line_sel = from_mem ? mem_line : (sel_way ? rd_line1 : rd_line0);
    assign word     = rbuf.addr.f.word;

    always_comb begin
        live_rsp.pc = rbuf.addr.raw;
        if (rbuf.uncached) begin
            live_rsp.inst0        = mem_line[31:0];
            live_rsp.inst1        = '0;
            live_rsp.second_valid = 1'b0;
        end else begin
            live_rsp.inst0        = line_sel[{word, 5'd0} +: 32];
            // pair only when the next word sits in the same aligned pair
            live_rsp.second_valid = ~word[0];
            live_rsp.inst1        = word[0] ? '0 : line_sel[{word | 2'b01, 5'd0} +: 32];
        end
    end

    ////////////////////////////////////////////////////////////
    // hold register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (result_en) begin
            held_valid <= hold;
        end else if (!hold) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (result_en) begin
            held_rsp <= live_rsp;
        end
    end

    // released the cycle hold drops
    assign show_held = held_valid && hold;
    assign rsp_valid = result_en || show_held;
    assign rsp       = show_held ? held_rsp : live_rsp;

endmodule

// File: src.f
common/icache_pkg.sv
icache/icache_tagv.sv
icache/icache_data.sv
icache/icache_lru.sv
icache/icache_ctrl.sv
icache/icache_top.sv
tests/tb_clock.sv
tests/tb_mem_model.sv
tests/icache_tb.sv

// File: tests/icache_tb.sv
`timescale 1ns/10ps

module icache_tb import icache_pkg::*; ();

    logic                  clk;
    logic                  reset;
    logic                  fetch_valid;
    fetch_req_s            fetch_req;
    logic                  hold;
    logic                  busy;
    logic                  op_ack;
    logic                  rsp_valid;
    fetch_rsp_s            rsp;
    logic                  mem_req;
    logic [31:0]           mem_addr;
    logic                  mem_uncached;
    logic                  mem_data_ok;
    logic [line_width-1:0] mem_line;
    logic [31:0]           cur_addr;
    logic                  cur_uncached;
    logic                  expect_hit;
    logic                  expect_miss;
    logic                  accepted;
    fetch_rsp_s            exp_rsp;
    logic [31:0]           exp_mem_addr;
    int                    errors = 0;
    int                    timeouts = 0;
    // a, b and c share set 3 and u sits in set 5
    logic [31:0]           addr_a = 32'h0001_0030;
    logic [31:0]           addr_b = 32'h0002_0030;
    logic [31:0]           addr_c = 32'h0003_0034;
    logic [31:0]           addr_u = 32'h0004_0058;

    tb_clock clock_i (.clk(clk), .reset(reset));

    tb_mem_model mem_i (
        .clk(clk), .reset(reset), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_uncached(mem_uncached), .mem_data_ok(mem_data_ok), .mem_line(mem_line)
    );

    icache_top dut_i (
        .clk(clk), .reset(reset), .fetch_valid(fetch_valid), .fetch_req(fetch_req),
        .hold(hold), .busy(busy), .op_ack(op_ack), .rsp_valid(rsp_valid), .rsp(rsp),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_uncached(mem_uncached),
        .mem_data_ok(mem_data_ok), .mem_line(mem_line)
    );

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        return (addr >> 2) ^ 32'hc0de0000;
    endfunction

    function automatic fetch_req_s make_req(input logic [31:0] addr, input logic unc,
                                            input logic op, input icache_op_e kind);
        fetch_req_s r;
        r          = '0;
        r.addr.raw = addr;
        r.uncached = unc;
        r.op       = op;
        r.op_kind  = kind;
        return r;
    endfunction

    assign accepted     = fetch_valid && !busy && !hold;
    assign exp_mem_addr = cur_uncached ? cur_addr : {cur_addr[31:4], 4'b0000};

    // pair rule on the model's words
    always_comb begin
        exp_rsp       = '0;
        exp_rsp.pc    = cur_addr;
        exp_rsp.inst0 = model_word(cur_addr);
        if (!cur_uncached && !cur_addr[2]) begin
            exp_rsp.inst1        = model_word(cur_addr + 32'd4);
            exp_rsp.second_valid = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_pc: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> rsp.pc == exp_rsp.pc
    ) else begin
        errors++;
        $display("ERROR: rsp.pc = %h, expected %h", $sampled(rsp.pc), $sampled(exp_rsp.pc));
    end

    a_inst0: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> rsp.inst0 == exp_rsp.inst0
    ) else begin
        errors++;
        $display("ERROR: rsp.inst0 = %h, expected %h", $sampled(rsp.inst0),
                 $sampled(exp_rsp.inst0));
    end

    a_inst1: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> rsp.inst1 == exp_rsp.inst1
    ) else begin
        errors++;
        $display("ERROR: rsp.inst1 = %h, expected %h", $sampled(rsp.inst1),
                 $sampled(exp_rsp.inst1));
    end

    a_second_valid: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> rsp.second_valid == exp_rsp.second_valid
    ) else begin
        errors++;
        $display("ERROR: rsp.second_valid = %h, expected %h", $sampled(rsp.second_valid),
                 $sampled(exp_rsp.second_valid));
    end

    a_hit: assert property (@(posedge clk) disable iff (reset)
        accepted && expect_hit |=> rsp_valid && !mem_req
    ) else begin
        errors++;
        $display("ERROR: rsp_valid = %h, mem_req = %h after a hit, expected 1 and 0",
                 $sampled(rsp_valid), $sampled(mem_req));
    end

    a_miss: assert property (@(posedge clk) disable iff (reset)
        accepted && expect_miss |=> mem_req && busy
    ) else begin
        errors++;
        $display("ERROR: mem_req = %h, busy = %h after a miss, expected 1 and 1",
                 $sampled(mem_req), $sampled(busy));
    end

    a_mem_addr: assert property (@(posedge clk) disable iff (reset)
        mem_req |-> mem_addr == exp_mem_addr && mem_uncached == cur_uncached
    ) else begin
        errors++;
        $display("ERROR: mem_addr = %h, mem_uncached = %h, expected %h and %h",
                 $sampled(mem_addr), $sampled(mem_uncached), $sampled(exp_mem_addr),
                 $sampled(cur_uncached));
    end

    // refill result straight from the line
    a_refill_done: assert property (@(posedge clk) disable iff (reset)
        mem_data_ok |=> rsp_valid && !busy
    ) else begin
        errors++;
        $display("ERROR: rsp_valid = %h, busy = %h after mem_data_ok, expected 1 and 0",
                 $sampled(rsp_valid), $sampled(busy));
    end

    a_op_ack: assert property (@(posedge clk) disable iff (reset)
        accepted && fetch_req.op |=> op_ack && !rsp_valid
    ) else begin
        errors++;
        $display("ERROR: op_ack = %h, rsp_valid = %h after an op, expected 1 and 0",
                 $sampled(op_ack), $sampled(rsp_valid));
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && hold |=> !hold || (rsp_valid && $stable(rsp))
    ) else begin
        errors++;
        $display("ERROR: rsp = %h, rsp_valid = %h changed while held", $sampled(rsp),
                 $sampled(rsp_valid));
    end

    a_hold_release: assert property (@(posedge clk) disable iff (reset)
        $fell(hold) && $past(rsp_valid) |-> !rsp_valid
    ) else begin
        errors++;
        $display("ERROR: rsp_valid = %h after hold fell, expected 0", $sampled(rsp_valid));
    end

    a_hold_no_accept: assert property (@(posedge clk) disable iff (reset)
        hold |=> $stable(dut_i.rbuf)
    ) else begin
        errors++;
        $display("request accepted while hold was high");
    end

    a_reset_state: assert property (@(posedge clk)
        reset |=> !rsp_valid && !busy && !op_ack && !mem_req
    ) else begin
        errors++;
        $display("ERROR: rsp_valid = %h, busy = %h, op_ack = %h, mem_req = %h after reset",
                 $sampled(rsp_valid), $sampled(busy), $sampled(op_ack), $sampled(mem_req));
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    // 0 acceptance, 1 fetch response, 2 op_ack, 3 reset released
    task automatic wait_for(input int what);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 64) begin
            @(posedge clk);
            case (what)
                0:       seen = !busy && !hold;
                1:       seen = rsp_valid;
                2:       seen = op_ack;
                default: seen = !reset;
            endcase
            n++;
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: waited 64 cycles for %s", what == 0 ? "request acceptance"
                     : what == 1 ? "a fetch response" : what == 2 ? "op_ack" : "reset release");
        end
    endtask

    task automatic fetch(input logic [31:0] addr, input logic unc, input logic exp_hit,
                         input logic exp_miss);
        @(posedge clk);
        fetch_valid  <= 1'b1;
        fetch_req    <= make_req(addr, unc, 1'b0, op_index_inv);
        cur_addr     <= addr;
        cur_uncached <= unc;
        expect_hit   <= exp_hit;
        expect_miss  <= exp_miss;
        wait_for(0);
        fetch_valid <= 1'b0;
        wait_for(1);
    endtask

    task automatic maintain(input logic [31:0] addr, input icache_op_e kind);
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_req   <= make_req(addr, 1'b0, 1'b1, kind);
        expect_hit  <= 1'b0;
        expect_miss <= 1'b0;
        wait_for(0);
        fetch_valid <= 1'b0;
        wait_for(2);
    endtask

    // hit result while hold is high with another request offered meanwhile
    task automatic fetch_under_hold(input logic [31:0] addr);
        @(posedge clk);
        fetch_valid  <= 1'b1;
        fetch_req    <= make_req(addr, 1'b0, 1'b0, op_index_inv);
        cur_addr     <= addr;
        cur_uncached <= 1'b0;
        expect_hit   <= 1'b1;
        expect_miss  <= 1'b0;
        wait_for(0);
        hold        <= 1'b1;
        fetch_req   <= make_req(addr ^ 32'h0000_0100, 1'b0, 1'b0, op_index_inv);
        expect_hit  <= 1'b0;
        repeat (5) @(posedge clk);
        fetch_valid <= 1'b0;
        @(posedge clk);
        hold <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    initial begin
        fetch_valid  = 1'b0;
        fetch_req    = '0;
        hold         = 1'b0;
        cur_addr     = '0;
        cur_uncached = 1'b0;
        expect_hit   = 1'b0;
        expect_miss  = 1'b0;
        wait_for(3);

        fetch(addr_a, 1'b0, 1'b0, 1'b1);
        fetch(addr_a + 32'h4, 1'b0, 1'b1, 1'b0);
        // a, b, a, c leaves b as the victim
        fetch(addr_b, 1'b0, 1'b0, 1'b1);
        fetch(addr_a + 32'h8, 1'b0, 1'b1, 1'b0);
        fetch(addr_c, 1'b0, 1'b0, 1'b1);
        fetch(addr_a, 1'b0, 1'b1, 1'b0);
        fetch(addr_b, 1'b0, 1'b0, 1'b1);
        // uncached leaves nothing behind
        fetch(addr_u, 1'b1, 1'b0, 1'b1);
        fetch(addr_u, 1'b0, 1'b0, 1'b1);
        fetch(addr_u + 32'h4, 1'b0, 1'b1, 1'b0);
        // uncached goes out even when the line is present
        fetch(addr_u, 1'b1, 1'b0, 1'b1);
        maintain(addr_a, op_index_inv);
        fetch(addr_a, 1'b0, 1'b0, 1'b1);
        fetch(addr_u, 1'b0, 1'b1, 1'b0);
        maintain(32'h0, op_inv_all);
        fetch(addr_u, 1'b0, 1'b0, 1'b1);
        fetch_under_hold(addr_u + 32'h4);

        repeat (3) @(posedge clk);
        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic reset
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: tests/tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model import icache_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  mem_req,
    input  logic [31:0]           mem_addr,
    input  logic                  mem_uncached,
    output logic                  mem_data_ok,
    output logic [line_width-1:0] mem_line
);

    integer      seed;
    logic        active;
    int unsigned wait_cnt;

    // every word carries its own word address
    function automatic logic [31:0] model_word(input logic [31:0] addr);
        return (addr >> 2) ^ 32'hc0de0000;
    endfunction

    function automatic logic [line_width-1:0] build_line(input logic [31:0] addr,
                                                         input logic unc);
        logic [line_width-1:0] line;
        line = '0;
        if (unc) begin
            line[31:0] = model_word(addr);
        end else begin
            for (int i = 0; i < line_width / 32; i++) begin
                line[32*i +: 32] = model_word(addr + 4 * i);
            end
        end
        return line;
    endfunction

    initial begin
        seed        = 32'h5719c97a;
        active      = 1'b0;
        wait_cnt    = 0;
        mem_data_ok = 1'b0;
        mem_line    = '0;
    end

    // mem_line stays put after the pulse, the cache reads it one cycle later
    always @(posedge clk) begin
        if (reset) begin
            active      <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_line    <= '0;
        end else if (mem_data_ok) begin
            mem_data_ok <= 1'b0;
            active      <= 1'b0;
        end else if (active) begin
            if (wait_cnt == 0) begin
                mem_data_ok <= 1'b1;
                mem_line    <= build_line(mem_addr, mem_uncached);
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (mem_req) begin
            // answer after 1 to 6 cycles
            active   <= 1'b1;
            wait_cnt <= $unsigned($random(seed)) % 6;
        end
    end

endmodule
